// File: common/loader_defines.svh
//////////////////////////////
// widths, region codes and strobe timing for the slot loader
// include wherever a macro below is used
//////////////////////////////

`ifndef LOADER_DEFINES_SVH
`define LOADER_DEFINES_SVH

// bridge bus widths
`define LOADER_ADDR_W       32
`define LOADER_DATA_W       32

// memory word address, bridge_addr[25:2]
`define LOADER_WORD_ADDR_W  24

// data-slot id and destination mask
`define LOADER_SLOT_ID_W    16
`define LOADER_DEST_W       3

// 64 MB memory window at 0x0, matched on bridge_addr[31:26]
`define LOADER_RAM_REGION   6'h00
// command region, matched on bridge_addr[31:24]
`define LOADER_CMD_REGION   8'hF8

// cycles the bram/sram strobe stays up
`define LOADER_SLOW_HOLD    3

`endif

// File: common/loader_pkg.sv
//////////////////////////////
// shared types for the slot loader
// modules import this inside their body, ports use scoped names
//////////////////////////////

`include "loader_defines.svh"

package loader_pkg;

    //////////////////////////////
    // vector types
    //////////////////////////////

    // bridge address and data
    typedef logic [`LOADER_ADDR_W-1:0]      bus_addr_t;
    typedef logic [`LOADER_DATA_W-1:0]      bus_data_t;

    // 32-bit word address into the memories
    typedef logic [`LOADER_WORD_ADDR_W-1:0] word_addr_t;

    // host data-slot identifier
    typedef logic [`LOADER_SLOT_ID_W-1:0]   slot_id_t;

    // one flag per destination memory
    typedef logic [`LOADER_DEST_W-1:0]      dest_mask_t;

    // flag positions inside dest_mask_t
    localparam int dest_sdram_bit = 0;
    localparam int dest_bram_bit  = 1;
    localparam int dest_sram_bit  = 2;

    //////////////////////////////
    // loader fsm
    //////////////////////////////

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack,
        st_wait_done
    } loader_state_t;

endpackage

// File: loader/loader_fsm.sv
//////////////////////////////
// data-slot read sequencer
// takes a load request, issues the read to the host and holds
// the destination mask until the host reports done
//////////////////////////////

module loader_fsm (
    input  logic                    clk_74a,
    input  logic                    reset_n,

    // load request
    input  logic                    load_req,
    input  loader_pkg::dest_mask_t  load_dest,
    input  loader_pkg::slot_id_t    slot_id,
    input  loader_pkg::bus_data_t   slot_offset,
    input  loader_pkg::bus_data_t   slot_bridgeaddr,
    input  loader_pkg::bus_data_t   slot_length,

    // host command handshake
    input  logic                    dataslot_ack,
    input  logic                    dataslot_done,
    output logic                    dataslot_read,
    output loader_pkg::slot_id_t    dataslot_id,
    output loader_pkg::bus_data_t   dataslot_offset,
    output loader_pkg::bus_data_t   dataslot_bridgeaddr,
    output loader_pkg::bus_data_t   dataslot_length,

    // towards capture and status
    output loader_pkg::dest_mask_t  active_dest,
    output logic                    load_start
);

    import loader_pkg::*;

    loader_state_t state;

    // request only counts with at least one destination set
    logic start_ok;

    assign start_ok = load_req && (load_dest != '0);

    //////////////////////////////
    // control state
    //////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            state         <= st_idle;
            dataslot_read <= 1'b0;
            active_dest   <= '0;
            load_start    <= 1'b0;
        end else begin
            // single-cycle pulse
            load_start <= 1'b0;

            case (state)
                st_idle: begin
                    if (start_ok) begin
                        dataslot_read <= 1'b1;
                        active_dest   <= load_dest;
                        load_start    <= 1'b1;
                        state         <= st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    // read held until host takes it
                    if (dataslot_ack) begin
                        dataslot_read <= 1'b0;
                        state         <= st_wait_done;
                    end
                end
                st_wait_done: begin
                    // bridge writes land here, done closes the window
                    if (dataslot_done) begin
                        active_dest <= '0;
                        state       <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // slot parameters, latched with the request
    always_ff @(posedge clk_74a) begin
        if (state == st_idle && start_ok) begin
            dataslot_id         <= slot_id;
            dataslot_offset     <= slot_offset;
            dataslot_bridgeaddr <= slot_bridgeaddr;
            dataslot_length     <= slot_length;
        end
    end

endmodule

// File: loader/word_capture.sv
//////////////////////////////
// turns bridge writes in the memory window into word writes
// strobes go out one cycle after the bridge write
//////////////////////////////

`include "loader_defines.svh"

module word_capture (
    input  logic                    clk_74a,
    input  logic                    reset_n,

    // bridge write side
    input  loader_pkg::bus_addr_t   bridge_addr,
    input  logic                    bridge_wr,
    input  loader_pkg::bus_data_t   bridge_wr_data,

    // destinations of the running load
    input  loader_pkg::dest_mask_t  active_dest,

    // registered word port
    output loader_pkg::word_addr_t  word_addr,
    output loader_pkg::bus_data_t   word_data,
    output logic                    sdram_word_wr,
    output logic                    slow_pulse,
    output loader_pkg::dest_mask_t  slow_dest,
    output logic                    word_accept
);

    import loader_pkg::*;

    logic ram_hit;
    logic accept;
    logic slow_sel;

    // 64 MB window, upper six address bits zero
    assign ram_hit = (bridge_addr[`LOADER_ADDR_W-1:26] == `LOADER_RAM_REGION);

    // only while a load is running
    assign accept = bridge_wr && ram_hit && (active_dest != '0);

    // bram or sram part of the load
    assign slow_sel = active_dest[dest_bram_bit] | active_dest[dest_sram_bit];

    //////////////////////////////
    // strobes
    //////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            sdram_word_wr <= 1'b0;
            slow_pulse    <= 1'b0;
            word_accept   <= 1'b0;
            slow_dest     <= '0;
        end else begin
            sdram_word_wr <= accept && active_dest[dest_sdram_bit];
            slow_pulse    <= accept && slow_sel;
            word_accept   <= accept;
            if (accept) begin
                // sdram flag stripped, slow side only
                slow_dest                <= '0;
                slow_dest[dest_bram_bit] <= active_dest[dest_bram_bit];
                slow_dest[dest_sram_bit] <= active_dest[dest_sram_bit];
            end
        end
    end

    // word address and data, held until the next accepted write
    always_ff @(posedge clk_74a) begin
        if (accept) begin
            word_addr <= bridge_addr[`LOADER_WORD_ADDR_W+1:2];
            word_data <= bridge_wr_data;
        end
    end

endmodule

// File: logic/slow_write_timer.sv
//////////////////////////////
// stretches a one-cycle pulse into a write strobe that a slower
// memory can catch, HOLD_CYCLES long
//////////////////////////////

`include "loader_defines.svh"

module slow_write_timer #(
    parameter int HOLD_CYCLES = `LOADER_SLOW_HOLD
) (
    input  logic clk_74a,
    input  logic reset_n,
    input  logic slow_pulse,
    output logic slow_word_wr
);

    // wide enough to hold HOLD_CYCLES itself
    localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

    logic [CNT_W-1:0] hold_cnt;

    //////////////////////////////
    // down-counter
    //////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            hold_cnt <= '0;
        end else if (slow_pulse) begin
            // new pulse restarts the window
            hold_cnt <= CNT_W'(HOLD_CYCLES);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // strobe up for every nonzero count
    assign slow_word_wr = (hold_cnt != '0);

endmodule

// File: logic/status_regs.sv
//////////////////////////////
// command-region read registers
// offset 0 status, offset 4 accepted word count, rest reads zero
//////////////////////////////

`include "loader_defines.svh"

module status_regs (
    input  logic                    clk_74a,
    input  logic                    reset_n,
    input  loader_pkg::bus_addr_t   bridge_addr,
    input  logic                    load_start,
    input  logic                    word_accept,
    input  loader_pkg::dest_mask_t  active_dest,
    output loader_pkg::bus_data_t   bridge_rd_data
);

    import loader_pkg::*;

    // register offsets inside the command region
    localparam logic [23:0] status_ofs = 24'h00_0000;
    localparam logic [23:0] count_ofs  = 24'h00_0004;

    bus_data_t word_count;
    bus_data_t status_word;
    logic      cmd_hit;

    //////////////////////////////
    // word counter
    //////////////////////////////

    // cleared per load, kept after done
    always_ff @(posedge clk_74a) begin
        if (!reset_n) begin
            word_count <= '0;
        end else if (load_start) begin
            word_count <= '0;
        end else if (word_accept) begin
            word_count <= word_count + 1'b1;
        end
    end

    //////////////////////////////
    // read mux
    //////////////////////////////

    // bit 0 busy, bits 3:1 destination mask
    always_comb begin
        status_word                  = '0;
        status_word[0]               = (active_dest != '0);
        status_word[`LOADER_DEST_W:1] = active_dest;
    end

    assign cmd_hit = (bridge_addr[31:24] == `LOADER_CMD_REGION);

    // combinational from address, host samples it with bridge_rd
    always_comb begin
        bridge_rd_data = '0;
        if (cmd_hit) begin
            case (bridge_addr[23:0])
                status_ofs: bridge_rd_data = status_word;
                count_ofs:  bridge_rd_data = word_count;
                default:    bridge_rd_data = '0;
            endcase
        end
    end

endmodule

// File: logic/slot_loader_top.sv
//////////////////////////////
// data-slot loader top level
// connects the bridge, the host command handshake and the word
// write ports of sdram, block ram and sram
//////////////////////////////

module slot_loader_top (
    input  logic                    clk_74a,
    input  logic                    reset_n,

    // bridge
    input  loader_pkg::bus_addr_t   bridge_addr,
    input  logic                    bridge_wr,
    input  loader_pkg::bus_data_t   bridge_wr_data,
    // read data is decoded from address alone, strobe not needed
    input  logic                    bridge_rd,
    output loader_pkg::bus_data_t   bridge_rd_data,

    // load request
    input  logic                    load_req,
    input  loader_pkg::dest_mask_t  load_dest,
    input  loader_pkg::slot_id_t    slot_id,
    input  loader_pkg::bus_data_t   slot_offset,
    input  loader_pkg::bus_data_t   slot_bridgeaddr,
    input  loader_pkg::bus_data_t   slot_length,

    // host command
    output logic                    dataslot_read,
    output loader_pkg::slot_id_t    dataslot_id,
    output loader_pkg::bus_data_t   dataslot_offset,
    output loader_pkg::bus_data_t   dataslot_bridgeaddr,
    output loader_pkg::bus_data_t   dataslot_length,
    input  logic                    dataslot_ack,
    input  logic                    dataslot_done,

    // memory word port
    output logic                    sdram_word_wr,
    output logic                    slow_word_wr,
    output loader_pkg::dest_mask_t  slow_dest,
    output loader_pkg::word_addr_t  word_addr,
    output loader_pkg::bus_data_t   word_data
);

    import loader_pkg::*;

    // fsm to capture and status
    dest_mask_t active_dest;
    logic       load_start;

    // capture to timer and status
    logic       slow_pulse;
    logic       word_accept;

    //////////////////////////////
    // host handshake
    //////////////////////////////

    loader_fsm loader_fsm_i (
        .clk_74a             (clk_74a),
        .reset_n             (reset_n),
        .load_req            (load_req),
        .load_dest           (load_dest),
        .slot_id             (slot_id),
        .slot_offset         (slot_offset),
        .slot_bridgeaddr     (slot_bridgeaddr),
        .slot_length         (slot_length),
        .dataslot_ack        (dataslot_ack),
        .dataslot_done       (dataslot_done),
        .dataslot_read       (dataslot_read),
        .dataslot_id         (dataslot_id),
        .dataslot_offset     (dataslot_offset),
        .dataslot_bridgeaddr (dataslot_bridgeaddr),
        .dataslot_length     (dataslot_length),
        .active_dest         (active_dest),
        .load_start          (load_start)
    );

    //////////////////////////////
    // word path
    //////////////////////////////

    word_capture word_capture_i (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .active_dest    (active_dest),
        .word_addr      (word_addr),
        .word_data      (word_data),
        .sdram_word_wr  (sdram_word_wr),
        .slow_pulse     (slow_pulse),
        .slow_dest      (slow_dest),
        .word_accept    (word_accept)
    );

    // bram and sram share the stretched strobe
    slow_write_timer slow_write_timer_i (
        .clk_74a      (clk_74a),
        .reset_n      (reset_n),
        .slow_pulse   (slow_pulse),
        .slow_word_wr (slow_word_wr)
    );

    //////////////////////////////
    // bridge readback
    //////////////////////////////

    status_regs status_regs_i (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_addr    (bridge_addr),
        .load_start     (load_start),
        .word_accept    (word_accept),
        .active_dest    (active_dest),
        .bridge_rd_data (bridge_rd_data)
    );

endmodule

// File: bench/tb_slot_loader.sv
//////////////////////////////
// testbench for the slot loader top level
// lfsr stimulus, host handshake model and a cycle model of the
// loader, compared against the DUT every cycle
//////////////////////////////

`include "loader_defines.svh"

module tb_slot_loader;

    import loader_pkg::*;

    localparam int clk_period      = 100;
    localparam int num_loads       = 24;
    // each load counts as request, data phase and readback
    localparam int num_ops         = num_loads * 3;
    localparam int watchdog_cycles = num_ops * 20 + 500;
    localparam int done_guard      = 40;

    // DUT inputs
    logic       clk_74a;
    logic       reset_n;
    bus_addr_t  bridge_addr;
    logic       bridge_wr;
    bus_data_t  bridge_wr_data;
    logic       bridge_rd;
    logic       load_req;
    dest_mask_t load_dest;
    slot_id_t   slot_id;
    bus_data_t  slot_offset;
    bus_data_t  slot_bridgeaddr;
    bus_data_t  slot_length;
    logic       dataslot_ack;
    logic       dataslot_done;

    // DUT outputs
    bus_data_t  bridge_rd_data;
    logic       dataslot_read;
    slot_id_t   dataslot_id;
    bus_data_t  dataslot_offset;
    bus_data_t  dataslot_bridgeaddr;
    bus_data_t  dataslot_length;
    logic       sdram_word_wr;
    logic       slow_word_wr;
    dest_mask_t slow_dest;
    word_addr_t word_addr;
    bus_data_t  word_data;

    int          errors;
    int          checks;
    string       test_name;
    logic [31:0] lfsr = 32'h0000_acb9;

    // host phase is idle (0), ack delay (1) or done delay (2)
    int host_phase;
    int host_wait;

    //////////////////////////////
    // reference model state
    //////////////////////////////

    loader_state_t m_state;
    logic          m_read;
    dest_mask_t    m_dest;
    slot_id_t      m_id;
    bus_data_t     m_offset;
    bus_data_t     m_baddr;
    bus_data_t     m_len;
    logic          m_param_valid;
    logic          m_start;
    logic          m_accept;
    logic          m_sdram_wr;
    logic          m_slow_pulse;
    dest_mask_t    m_slow_dest;
    int            m_slow_cnt;
    bus_data_t     m_count;
    word_addr_t    m_waddr;
    bus_data_t     m_wdata;
    logic          m_word_valid;

    slot_loader_top slot_loader_top_i (
        .clk_74a             (clk_74a),
        .reset_n             (reset_n),
        .bridge_addr         (bridge_addr),
        .bridge_wr           (bridge_wr),
        .bridge_wr_data      (bridge_wr_data),
        .bridge_rd           (bridge_rd),
        .bridge_rd_data      (bridge_rd_data),
        .load_req            (load_req),
        .load_dest           (load_dest),
        .slot_id             (slot_id),
        .slot_offset         (slot_offset),
        .slot_bridgeaddr     (slot_bridgeaddr),
        .slot_length         (slot_length),
        .dataslot_read       (dataslot_read),
        .dataslot_id         (dataslot_id),
        .dataslot_offset     (dataslot_offset),
        .dataslot_bridgeaddr (dataslot_bridgeaddr),
        .dataslot_length     (dataslot_length),
        .dataslot_ack        (dataslot_ack),
        .dataslot_done       (dataslot_done),
        .sdram_word_wr       (sdram_word_wr),
        .slow_word_wr        (slow_word_wr),
        .slow_dest           (slow_dest),
        .word_addr           (word_addr),
        .word_data           (word_data)
    );

    initial begin
        clk_74a = 1'b0;
        forever #(clk_period / 2) clk_74a = ~clk_74a;
    end

    // fibonacci lfsr with taps 32 22 2 1
    // one step for each bit returned
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // command region holds status at 0 and count at 4
    function automatic bus_data_t expected_read(input bus_addr_t addr);
        bus_data_t val;
        val = '0;
        if (addr[31:24] == `LOADER_CMD_REGION) begin
            if (addr[23:0] == 24'h0) begin
                val = {28'b0, m_dest, (m_dest != 3'b0)};
            end else if (addr[23:0] == 24'h4) begin
                val = m_count;
            end
        end
        return val;
    endfunction

    //////////////////////////////
    // host and model
    //////////////////////////////

    // ack and done after 0..7 idle cycles each
    task automatic host_drive();
        dataslot_ack  = 1'b0;
        dataslot_done = 1'b0;
        if (host_phase == 0 && dataslot_read === 1'b1) begin
            host_phase = 1;
            host_wait  = rand_bits(3);
        end
        if (host_phase == 1) begin
            if (host_wait == 0) begin
                dataslot_ack = 1'b1;
                host_phase   = 2;
                host_wait    = rand_bits(3);
            end else begin
                host_wait--;
            end
        end else if (host_phase == 2) begin
            if (host_wait == 0) begin
                dataslot_done = 1'b1;
                host_phase    = 0;
            end else begin
                host_wait--;
            end
        end
    endtask

    // advances the loader model by one clock edge
    task automatic update_model();
        logic accept;
        logic start;
        if (!reset_n) begin
            m_state      = st_idle;
            m_read       = 1'b0;
            m_dest       = '0;
            m_start      = 1'b0;
            m_accept     = 1'b0;
            m_sdram_wr   = 1'b0;
            m_slow_pulse = 1'b0;
            m_slow_dest  = '0;
            m_slow_cnt   = 0;
            m_count      = '0;
        end else begin
            accept = bridge_wr && (bridge_addr[31:26] == `LOADER_RAM_REGION) && (m_dest != 0);
            start  = (m_state == st_idle) && load_req && (load_dest != 0);
            // count and timer see last cycle's registered pulses
            if (m_start) begin
                m_count = '0;
            end else if (m_accept) begin
                m_count = m_count + 1;
            end
            if (m_slow_pulse) begin
                m_slow_cnt = `LOADER_SLOW_HOLD;
            end else if (m_slow_cnt != 0) begin
                m_slow_cnt--;
            end
            m_start      = start;
            m_accept     = accept;
            m_sdram_wr   = accept && m_dest[0];
            m_slow_pulse = accept && (m_dest[1] || m_dest[2]);
            if (accept) begin
                m_slow_dest  = {m_dest[2], m_dest[1], 1'b0};
                m_waddr      = bridge_addr[25:2];
                m_wdata      = bridge_wr_data;
                m_word_valid = 1'b1;
            end
            // handshake goes last since accept uses the old destination
            case (m_state)
                st_idle: begin
                    if (start) begin
                        m_read        = 1'b1;
                        m_dest        = load_dest;
                        m_id          = slot_id;
                        m_offset      = slot_offset;
                        m_baddr       = slot_bridgeaddr;
                        m_len         = slot_length;
                        m_param_valid = 1'b1;
                        m_state       = st_wait_ack;
                    end
                end
                st_wait_ack: begin
                    if (dataslot_ack) begin
                        m_read  = 1'b0;
                        m_state = st_wait_done;
                    end
                end
                default: begin
                    if (dataslot_done) begin
                        m_dest  = '0;
                        m_state = st_idle;
                    end
                end
            endcase
        end
    endtask

    task automatic check_outputs();
        check_value("dataslot_read", m_read, dataslot_read);
        check_value("sdram_word_wr", m_sdram_wr, sdram_word_wr);
        check_value("slow_word_wr", (m_slow_cnt != 0), slow_word_wr);
        check_value("slow_dest", m_slow_dest, slow_dest);
        check_value("bridge_rd_data", expected_read(bridge_addr), bridge_rd_data);
        // latched values only exist after the first load or write
        if (m_param_valid) begin
            check_value("dataslot_id", m_id, dataslot_id);
            check_value("dataslot_offset", m_offset, dataslot_offset);
            check_value("dataslot_bridgeaddr", m_baddr, dataslot_bridgeaddr);
            check_value("dataslot_length", m_len, dataslot_length);
        end
        if (m_word_valid) begin
            check_value("word_addr", m_waddr, word_addr);
            check_value("word_data", m_wdata, word_data);
        end
    endtask

    // inputs change on the falling edge and outputs are checked on the next one
    task automatic run_cycle();
        host_drive();
        @(posedge clk_74a);
        update_model();
        @(negedge clk_74a);
        check_outputs();
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic start_request();
        load_req        = 1'b1;
        load_dest       = 3'(rand_bits(3));
        slot_id         = 16'(rand_bits(16));
        slot_offset     = rand_bits(32);
        slot_bridgeaddr = rand_bits(32);
        slot_length     = rand_bits(32);
    endtask

    task automatic random_stimulus(input bit in_load);
        logic [31:0] pick;
        bridge_wr = 1'b0;
        bridge_rd = 1'b0;
        load_req  = 1'b0;
        pick      = rand_bits(2);
        case (pick[1:0])
            2'd0, 2'd1: begin
                bridge_wr      = 1'b1;
                bridge_wr_data = rand_bits(32);
                pick           = rand_bits(2);
                // three in four writes hit the memory window
                if (pick[1:0] != 2'd0) begin
                    bridge_addr = {`LOADER_RAM_REGION, 26'(rand_bits(26))};
                end else begin
                    bridge_addr     = rand_bits(32);
                    bridge_addr[31] = 1'b1;
                end
            end
            2'd2: begin
                bridge_rd = 1'b1;
                pick      = rand_bits(2);
                case (pick[1:0])
                    2'd0:    bridge_addr = 32'hF800_0000;
                    2'd1:    bridge_addr = 32'hF800_0004;
                    2'd2:    bridge_addr = {`LOADER_CMD_REGION, 24'(rand_bits(24))};
                    default: bridge_addr = rand_bits(32);
                endcase
            end
            default: begin
                // stray request that the busy loader ignores
                if (in_load) begin
                    start_request();
                end
            end
        endcase
    endtask

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run did not finish",
                 watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        int guard;
        errors          = 0;
        checks          = 0;
        host_phase      = 0;
        host_wait       = 0;
        m_param_valid   = 1'b0;
        m_word_valid    = 1'b0;
        reset_n         = 1'b0;
        bridge_addr     = '0;
        bridge_wr       = 1'b0;
        bridge_wr_data  = '0;
        bridge_rd       = 1'b0;
        load_req        = 1'b0;
        load_dest       = '0;
        slot_id         = '0;
        slot_offset     = '0;
        slot_bridgeaddr = '0;
        slot_length     = '0;
        dataslot_ack    = 1'b0;
        dataslot_done   = 1'b0;

        test_name = "reset";
        repeat (4) run_cycle();
        reset_n     = 1'b1;
        bridge_rd   = 1'b1;
        bridge_addr = 32'hF800_0000;
        run_cycle();
        check_value("status_after_reset", 32'h0, bridge_rd_data);
        bridge_addr = 32'hF800_0004;
        run_cycle();
        check_value("count_after_reset", 32'h0, bridge_rd_data);

        for (int n = 0; n < num_loads; n++) begin
            // no load running so nothing is accepted
            test_name = "idle_writes";
            repeat (6) begin
                random_stimulus(1'b0);
                run_cycle();
            end

            test_name = "load_start";
            bridge_wr = 1'b0;
            bridge_rd = 1'b0;
            start_request();
            run_cycle();

            // data phase until the host has finished the handshake
            test_name = "load_data";
            guard     = 0;
            while ((dataslot_read === 1'b1 || host_phase != 0) && guard < done_guard) begin
                random_stimulus(1'b1);
                run_cycle();
                guard++;
            end
            assert (guard < done_guard) else begin
                errors++;
                $display("host handshake of load %0d did not finish within %0d cycles",
                         n, done_guard);
            end

            // count must survive the end of the load
            test_name   = "after_done";
            load_req    = 1'b0;
            bridge_wr   = 1'b0;
            bridge_rd   = 1'b1;
            bridge_addr = 32'hF800_0004;
            run_cycle();
            bridge_addr = 32'hF800_0000;
            run_cycle();
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+common
common/loader_pkg.sv
loader/loader_fsm.sv
loader/word_capture.sv
logic/slow_write_timer.sv
logic/status_regs.sv
logic/slot_loader_top.sv
bench/tb_slot_loader.sv

// File: Bender.yml
package:
  name: slot_loader

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/loader_pkg.sv
      - loader/loader_fsm.sv
      - loader/word_capture.sv
      - logic/slow_write_timer.sv
      - logic/status_regs.sv
      - logic/slot_loader_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_slot_loader.sv
